// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_wb_dual_port_ram
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// File: clkgate_optional.sv
`timescale 1ns/10ps
`default_nettype none

module clkgate_optional
(
  input  wire  clk_i,
  input  wire  en_i,
  input  wire  bypass_i,
  output logic gated_clock_o
);

  logic en_latched;

  // enable may only change while the clock is low
  always_latch
  begin
    if (!clk_i)
      en_latched = en_i | bypass_i;
  end

  assign gated_clock_o = clk_i & en_latched;

endmodule

`default_nettype wire

// File: mem2p_cfg.svh
`ifndef MEM2P_CFG_SVH
`define MEM2P_CFG_SVH

`default_nettype none

// ------------------------------
// memory geometry
// ------------------------------

// word width in bits, multiple of 8
`define MEM2P_WIDTH 32

// number of words
`define MEM2P_ELS 256

// 1 puts a clock gate in front of the array
`define MEM2P_CLOCK_GATING 1

`default_nettype wire

`endif

// File: mem2p_pkg.sv
`include "mem2p_cfg.svh"

`default_nettype none

package mem2p_pkg;

  // derived widths
  localparam int addr_width_p = $clog2(`MEM2P_ELS);
  localparam int mask_width_p = `MEM2P_WIDTH / 8;

  // memory port opcode
  typedef enum logic
  {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_e;

  // wishbone adapter state
  typedef enum logic
  {
    wb_idle = 1'b0,
    wb_ack  = 1'b1
  } wb_state_e;

endpackage

`default_nettype wire

// File: mem_2rw_sync_mask_write_byte.sv
`include "mem2p_cfg.svh"

`timescale 1ns/10ps
`default_nettype none

module mem_2rw_sync_mask_write_byte
#(
  parameter int width_p = `MEM2P_WIDTH,
  parameter int els_p   = `MEM2P_ELS
)
(
  input wire          clk_i,
  mem_port_if.memory  a,
  mem_port_if.memory  b
);

  wire clk_lo;

  // array clock runs only while a port is busy
  if (`MEM2P_CLOCK_GATING)
  begin : g_gate
    clkgate_optional icg
    (
      .clk_i         (clk_i),
      .en_i          (a.v | b.v),
      .bypass_i      (1'b0),
      .gated_clock_o (clk_lo)
    );
  end
  else
  begin : g_free
    assign clk_lo = clk_i;
  end

  mem_2rw_sync_mask_write_byte_synth
  #(
    .width_p (width_p),
    .els_p   (els_p)
  ) synth
  (
    .clk_i (clk_lo),
    .a     (a),
    .b     (b)
  );

endmodule

`default_nettype wire

// File: mem_2rw_sync_mask_write_byte_synth.sv
`timescale 1ns/10ps
`default_nettype none

module mem_2rw_sync_mask_write_byte_synth import mem2p_pkg::*;
#(
  parameter int width_p = 32,
  parameter int els_p   = 256
)
(
  input wire          clk_i,
  mem_port_if.memory  a,
  mem_port_if.memory  b
);

  localparam int lanes_lp = width_p / 8;

  logic [width_p-1:0]  mem_r [els_p];
  logic [width_p-1:0]  a_rdata_r;
  logic [width_p-1:0]  b_rdata_r;
  logic [lanes_lp-1:0] a_we;
  logic [lanes_lp-1:0] b_we;
  logic                a_rd;
  logic                b_rd;

  // ------------------------------
  // per-lane write enables
  // ------------------------------
  assign a_we = (a.v && a.op == mem_op_write) ? a.mask : '0;
  assign b_we = (b.v && b.op == mem_op_write) ? b.mask : '0;
  assign a_rd = a.v && a.op == mem_op_read;
  assign b_rd = b.v && b.op == mem_op_read;

  // port b first, so port a overrides it on a shared lane
  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < lanes_lp; i++)
    begin
      if (b_we[i])
        mem_r[b.addr][i*8 +: 8] <= b.data[i*8 +: 8];
      if (a_we[i])
        mem_r[a.addr][i*8 +: 8] <= a.data[i*8 +: 8];
    end
  end

  // ------------------------------
  // read data, old word on collision
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (a_rd)
      a_rdata_r <= mem_r[a.addr];
    if (b_rd)
      b_rdata_r <= mem_r[b.addr];
  end

  assign a.rdata = a_rdata_r;
  assign b.rdata = b_rdata_r;

endmodule

`default_nettype wire

// File: mem_port_if.sv
`include "mem2p_cfg.svh"

`timescale 1ns/10ps
`default_nettype none

interface mem_port_if import mem2p_pkg::*; ();

  // request
  logic                    v;
  mem_op_e                 op;
  logic [addr_width_p-1:0] addr;
  logic [`MEM2P_WIDTH-1:0] data;
  logic [mask_width_p-1:0] mask;

  // response, one cycle after a read
  logic [`MEM2P_WIDTH-1:0] rdata;

  modport issuer
  (
    output v, op, addr, data, mask,
    input  rdata
  );

  modport memory
  (
    input  v, op, addr, data, mask,
    output rdata
  );

endinterface

`default_nettype wire

// File: sources.f
+incdir+.
mem2p_pkg.sv
mem_port_if.sv
clkgate_optional.sv
mem_2rw_sync_mask_write_byte_synth.sv
mem_2rw_sync_mask_write_byte.sv
wb_mem_port.sv
wb_dual_port_ram.sv
wb_dual_port_ram_assertions.sv
tb_wb_dual_port_ram.sv

// File: tb_wb_dual_port_ram.sv
`include "mem2p_cfg.svh"

`timescale 1ns/10ps
`default_nettype none

module tb_wb_dual_port_ram import mem2p_pkg::*; ();

  localparam int timeout_lp = 20;

  logic                    clk;
  logic                    arst_n;
  logic                    wb_a_cyc;
  logic                    wb_a_stb;
  logic                    wb_a_we;
  logic [addr_width_p-1:0] wb_a_adr;
  logic [mask_width_p-1:0] wb_a_sel;
  logic [`MEM2P_WIDTH-1:0] wb_a_dat_i;
  logic [`MEM2P_WIDTH-1:0] wb_a_dat_o;
  logic                    wb_a_ack;
  logic                    wb_b_cyc;
  logic                    wb_b_stb;
  logic                    wb_b_we;
  logic [addr_width_p-1:0] wb_b_adr;
  logic [mask_width_p-1:0] wb_b_sel;
  logic [`MEM2P_WIDTH-1:0] wb_b_dat_i;
  logic [`MEM2P_WIDTH-1:0] wb_b_dat_o;
  logic                    wb_b_ack;

  logic [`MEM2P_WIDTH-1:0] ref_mem [`MEM2P_ELS];
  int                      checks;
  int                      errors;
  int                      timeouts;

  wb_dual_port_ram dut
  (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .wb_a_cyc_i (wb_a_cyc),
    .wb_a_stb_i (wb_a_stb),
    .wb_a_we_i  (wb_a_we),
    .wb_a_adr_i (wb_a_adr),
    .wb_a_sel_i (wb_a_sel),
    .wb_a_dat_i (wb_a_dat_i),
    .wb_a_dat_o (wb_a_dat_o),
    .wb_a_ack_o (wb_a_ack),
    .wb_b_cyc_i (wb_b_cyc),
    .wb_b_stb_i (wb_b_stb),
    .wb_b_we_i  (wb_b_we),
    .wb_b_adr_i (wb_b_adr),
    .wb_b_sel_i (wb_b_sel),
    .wb_b_dat_i (wb_b_dat_i),
    .wb_b_dat_o (wb_b_dat_o),
    .wb_b_ack_o (wb_b_ack)
  );

  bind wb_dual_port_ram wb_dual_port_ram_assertions u_assert
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cyc_i    ({wb_b_cyc_i, wb_a_cyc_i}),
    .stb_i    ({wb_b_stb_i, wb_a_stb_i}),
    .ack_i    ({wb_b_ack_o, wb_a_ack_o})
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] fill_word(input logic [7:0] adr);
    return {adr, ~adr, adr ^ 8'h5a, adr + 8'h3c};
  endfunction

  function automatic logic [31:0] ref_read(input logic [7:0] adr);
    return ref_mem[adr];
  endfunction

  // port b lands only where port a leaves the same word's lane alone
  function automatic void ref_write(input logic a_wr, input logic [7:0] a_adr,
                                    input logic [3:0] a_sel, input logic [31:0] a_dat,
                                    input logic b_wr, input logic [7:0] b_adr,
                                    input logic [3:0] b_sel, input logic [31:0] b_dat);
    for (int i = 0; i < mask_width_p; i++)
    begin
      if (b_wr && b_sel[i] && !(a_wr && a_adr == b_adr && a_sel[i]))
        ref_mem[b_adr][i*8 +: 8] = b_dat[i*8 +: 8];
      if (a_wr && a_sel[i])
        ref_mem[a_adr][i*8 +: 8] = a_dat[i*8 +: 8];
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ------------------------------
  // bus transfers, called on a falling edge
  // ------------------------------
  task automatic dual_xfer(input logic a_en, input logic a_we, input logic [7:0] a_adr,
                           input logic [3:0] a_sel, input logic [31:0] a_dat,
                           input logic b_en, input logic b_we, input logic [7:0] b_adr,
                           input logic [3:0] b_sel, input logic [31:0] b_dat);
    logic [31:0] a_exp;
    logic [31:0] b_exp;
    logic        a_done;
    logic        b_done;
    int          wait_n;
    a_exp = ref_read(a_adr);
    b_exp = ref_read(b_adr);
    ref_write(a_en && a_we, a_adr, a_sel, a_dat, b_en && b_we, b_adr, b_sel, b_dat);
    wb_a_cyc = a_en;
    wb_a_stb = a_en;
    wb_a_we = a_we;
    wb_a_adr = a_adr;
    wb_a_sel = a_sel;
    wb_a_dat_i = a_dat;
    wb_b_cyc = b_en;
    wb_b_stb = b_en;
    wb_b_we = b_we;
    wb_b_adr = b_adr;
    wb_b_sel = b_sel;
    wb_b_dat_i = b_dat;
    a_done = !a_en;
    b_done = !b_en;
    wait_n = 0;
    while (!(a_done && b_done) && wait_n < timeout_lp)
    begin
      @(negedge clk);
      wait_n++;
      if (!a_done && wb_a_ack)
      begin
        a_done = 1'b1;
        if (wait_n != 1)
        begin
          errors++;
          $display("port a ack came after %0d cycles instead of one", wait_n);
        end
        if (!a_we)
          check_value("wb_a_dat_o", wb_a_dat_o, a_exp);
      end
      if (!b_done && wb_b_ack)
      begin
        b_done = 1'b1;
        if (wait_n != 1)
        begin
          errors++;
          $display("port b ack came after %0d cycles instead of one", wait_n);
        end
        if (!b_we)
          check_value("wb_b_dat_o", wb_b_dat_o, b_exp);
      end
    end
    if (!(a_done && b_done))
    begin
      timeouts++;
      $display("timed out waiting for ack on a bus transfer");
    end
    // hold the request through the ack edge
    @(negedge clk);
    wb_a_cyc = 1'b0;
    wb_a_stb = 1'b0;
    wb_b_cyc = 1'b0;
    wb_b_stb = 1'b0;
  endtask

  task automatic port_a_xfer(input logic we, input logic [7:0] adr,
                             input logic [3:0] sel, input logic [31:0] dat);
    dual_xfer(1'b1, we, adr, sel, dat, 1'b0, 1'b0, 8'h00, 4'h0, 32'h0);
  endtask

  task automatic port_b_xfer(input logic we, input logic [7:0] adr,
                             input logic [3:0] sel, input logic [31:0] dat);
    dual_xfer(1'b0, 1'b0, 8'h00, 4'h0, 32'h0, 1'b1, we, adr, sel, dat);
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] e;
    r = $urandom(73415);
    checks = 0;
    errors = 0;
    timeouts = 0;
    arst_n = 1'b0;
    wb_a_cyc = 1'b0;
    wb_a_stb = 1'b0;
    wb_a_we = 1'b0;
    wb_a_adr = '0;
    wb_a_sel = '0;
    wb_a_dat_i = '0;
    wb_b_cyc = 1'b0;
    wb_b_stb = 1'b0;
    wb_b_we = 1'b0;
    wb_b_adr = '0;
    wb_b_sel = '0;
    wb_b_dat_i = '0;
    repeat (10)
    begin
      @(negedge clk);
      check_value("wb_a_ack_o", {31'b0, wb_a_ack}, 32'h0);
      check_value("wb_b_ack_o", {31'b0, wb_b_ack}, 32'h0);
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_value("wb_a_ack_o", {31'b0, wb_a_ack}, 32'h0);
    check_value("wb_b_ack_o", {31'b0, wb_b_ack}, 32'h0);

    // known contents everywhere
    for (int i = 0; i < `MEM2P_ELS; i++)
      port_a_xfer(1'b1, i[7:0], 4'hf, fill_word(i[7:0]));

    // full words across ports
    repeat (20)
    begin
      r = $urandom();
      d = $urandom();
      port_a_xfer(1'b1, r[7:0], 4'hf, d);
      port_b_xfer(1'b0, r[7:0], 4'h0, 32'h0);
      port_b_xfer(1'b1, r[15:8], 4'hf, ~d);
      port_a_xfer(1'b0, r[15:8], 4'h0, 32'h0);
    end

    // byte lanes
    repeat (30)
    begin
      r = $urandom();
      d = $urandom();
      port_a_xfer(1'b1, r[7:0], 4'hf, fill_word(r[7:0]));
      port_b_xfer(1'b1, r[7:0], r[11:8], d);
      port_a_xfer(1'b0, r[7:0], 4'h0, 32'h0);
    end

    // same-word writes, port a wins
    repeat (30)
    begin
      r = $urandom();
      d = $urandom();
      e = $urandom();
      dual_xfer(1'b1, 1'b1, r[7:0], r[11:8], d, 1'b1, 1'b1, r[7:0], r[15:12], e);
      port_a_xfer(1'b0, r[7:0], 4'h0, 32'h0);
    end

    // read meets write, old word first
    repeat (20)
    begin
      r = $urandom();
      d = $urandom();
      dual_xfer(1'b1, 1'b0, r[7:0], 4'h0, 32'h0, 1'b1, 1'b1, r[7:0], 4'hf, d);
      dual_xfer(1'b1, 1'b1, r[7:0], r[11:8], ~d, 1'b1, 1'b0, r[7:0], 4'h0, 32'h0);
      dual_xfer(1'b1, 1'b0, r[7:0], 4'h0, 32'h0, 1'b1, 1'b0, r[7:0], 4'h0, 32'h0);
    end

    // mixed traffic, small address range for collisions
    repeat (200)
    begin
      r = $urandom();
      d = $urandom();
      e = $urandom();
      dual_xfer(1'b1, r[0], r[1] ? {4'h0, r[11:8]} : r[19:12], r[23:20], d,
                1'b1, r[2], r[3] ? {4'h0, r[27:24]} : r[31:24], r[7:4], e);
    end

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_dual_port_ram.sv
`include "mem2p_cfg.svh"

`timescale 1ns/10ps
`default_nettype none

module wb_dual_port_ram import mem2p_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     arst_n_i,

  // ------------------------------
  // wishbone port a
  // ------------------------------
  input  wire                     wb_a_cyc_i,
  input  wire                     wb_a_stb_i,
  input  wire                     wb_a_we_i,
  input  wire  [addr_width_p-1:0] wb_a_adr_i,
  input  wire  [mask_width_p-1:0] wb_a_sel_i,
  input  wire  [`MEM2P_WIDTH-1:0] wb_a_dat_i,
  output logic [`MEM2P_WIDTH-1:0] wb_a_dat_o,
  output logic                    wb_a_ack_o,

  // ------------------------------
  // wishbone port b
  // ------------------------------
  input  wire                     wb_b_cyc_i,
  input  wire                     wb_b_stb_i,
  input  wire                     wb_b_we_i,
  input  wire  [addr_width_p-1:0] wb_b_adr_i,
  input  wire  [mask_width_p-1:0] wb_b_sel_i,
  input  wire  [`MEM2P_WIDTH-1:0] wb_b_dat_i,
  output logic [`MEM2P_WIDTH-1:0] wb_b_dat_o,
  output logic                    wb_b_ack_o
);

  mem_port_if port_a_if ();
  mem_port_if port_b_if ();

  wb_mem_port u_port_a
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_a_cyc_i),
    .wb_stb_i (wb_a_stb_i),
    .wb_we_i  (wb_a_we_i),
    .wb_adr_i (wb_a_adr_i),
    .wb_sel_i (wb_a_sel_i),
    .wb_dat_i (wb_a_dat_i),
    .wb_dat_o (wb_a_dat_o),
    .wb_ack_o (wb_a_ack_o),
    .mem      (port_a_if.issuer)
  );

  wb_mem_port u_port_b
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_b_cyc_i),
    .wb_stb_i (wb_b_stb_i),
    .wb_we_i  (wb_b_we_i),
    .wb_adr_i (wb_b_adr_i),
    .wb_sel_i (wb_b_sel_i),
    .wb_dat_i (wb_b_dat_i),
    .wb_dat_o (wb_b_dat_o),
    .wb_ack_o (wb_b_ack_o),
    .mem      (port_b_if.issuer)
  );

  // port a has write priority inside the array
  mem_2rw_sync_mask_write_byte
  #(
    .width_p (`MEM2P_WIDTH),
    .els_p   (`MEM2P_ELS)
  ) u_mem
  (
    .clk_i (clk_i),
    .a     (port_a_if.memory),
    .b     (port_b_if.memory)
  );

endmodule

`default_nettype wire

// File: wb_dual_port_ram_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module wb_dual_port_ram_assertions
(
  input wire       clk_i,
  input wire       arst_n_i,
  input wire [1:0] cyc_i,
  input wire [1:0] stb_i,
  input wire [1:0] ack_i
);

  // index 0 is port a, index 1 is port b
  for (genvar i = 0; i < 2; i++)
  begin : g_port
    ack_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !ack_i[i])
      else $error("ack high during reset on port %0d", i);

    ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ack_i[i] |=> !ack_i[i])
      else $error("ack held for two cycles on port %0d", i);

    ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ack_i[i] |-> $past(cyc_i[i] && stb_i[i]))
      else $error("ack without a request on port %0d", i);

    // adapter idle again right after ack
    next_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ack_i[i] ##1 (cyc_i[i] && stb_i[i]) |=> ack_i[i])
      else $error("request after ack not accepted on port %0d", i);
  end

endmodule

`default_nettype wire

// File: wb_mem_port.sv
`include "mem2p_cfg.svh"

`timescale 1ns/10ps
`default_nettype none

module wb_mem_port import mem2p_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,
  input  wire                     wb_we_i,
  input  wire  [addr_width_p-1:0] wb_adr_i,
  input  wire  [mask_width_p-1:0] wb_sel_i,
  input  wire  [`MEM2P_WIDTH-1:0] wb_dat_i,
  output logic [`MEM2P_WIDTH-1:0] wb_dat_o,
  output logic                    wb_ack_o,
  mem_port_if.issuer              mem
);

  wb_state_e state_r;
  wb_state_e state_n;
  logic      req;

  // ------------------------------
  // one access per bus cycle
  // ------------------------------
  assign req = (state_r == wb_idle) && wb_cyc_i && wb_stb_i;

  always_comb
  begin
    case (state_r)
      wb_idle: state_n = req ? wb_ack : wb_idle;
      wb_ack:  state_n = wb_idle;
      default: state_n = wb_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_r <= wb_idle;
    else
      state_r <= state_n;
  end

  // memory request
  assign mem.v    = req;
  assign mem.op   = wb_we_i ? mem_op_write : mem_op_read;
  assign mem.addr = wb_adr_i;
  assign mem.data = wb_dat_i;
  assign mem.mask = wb_sel_i;

  // read data is ready while ack is high
  assign wb_ack_o = (state_r == wb_ack);
  assign wb_dat_o = mem.rdata;

endmodule

`default_nettype wire
